//--- design/cpu_alu.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_alu import cpu_bus_pkg::*, cpu_isa_pkg::*; (
    input  alu_op_e alu_op,
    input  byte_t   a_operand,
    input  byte_t   b_operand,
    input  byte_t   status,
    input  opcode_u opcode,
    output byte_t   alu_result,
    output byte_t   alu_flags
);

    logic       subtract;           // Adder takes inverted B
    logic       compare;
    logic       carry_in;
    byte_t      b_eff;
    logic [8:0] sum;
    byte_t      nz_src;             // Value that N and Z follow

    // Shared adder ------------------------------------------------
    assign compare  = alu_op == ALU_CMP || alu_op == ALU_CPX;
    assign subtract = compare || alu_op == ALU_SBC;
    assign carry_in = compare ? 1'b1 : status[FLAG_C];          // Compare is A - B
    assign b_eff    = subtract ? ~b_operand : b_operand;
    assign sum      = {1'b0, a_operand} + {1'b0, b_eff} + {8'd0, carry_in};

    always_comb begin
        alu_result = b_operand;                                  // PASS by default
        alu_flags  = status;
        case (alu_op)
            ALU_ORA: alu_result = a_operand | b_operand;
            ALU_AND: alu_result = a_operand & b_operand;
            ALU_EOR: alu_result = a_operand ^ b_operand;
            ALU_ADC, ALU_SBC: begin
                alu_result        = sum[7:0];                    // Binary only
                alu_flags[FLAG_C] = sum[8];
                alu_flags[FLAG_V] = ~(a_operand[7] ^ b_eff[7]) & (a_operand[7] ^ sum[7]);
            end
            ALU_CMP, ALU_CPX: begin
                alu_result        = a_operand;
                alu_flags[FLAG_C] = sum[8];                      // No borrow
            end
            ALU_INC: alu_result = b_operand + 8'd1;
            ALU_DEC: alu_result = b_operand - 8'd1;
            ALU_FLAGSET: begin
                case (opcode.raw[7:6])
                    2'b00:   alu_flags[FLAG_C] = opcode.raw[5];
                    2'b01:   alu_flags[FLAG_I] = opcode.raw[5];
                    2'b10:   alu_flags[FLAG_V] = 1'b0;           // CLV only
                    default: alu_flags[FLAG_D] = opcode.raw[5];
                endcase
            end
            default: alu_result = b_operand;
        endcase

        nz_src = compare ? sum[7:0] : alu_result;
        if (alu_op != ALU_FLAGSET) begin
            alu_flags[FLAG_N] = nz_src[7];
            alu_flags[FLAG_Z] = nz_src == 8'd0;
        end
    end

endmodule

`default_nettype wire

//--- design/cpu_bus_pkg.sv
`default_nettype none

package cpu_bus_pkg;

    localparam int ADDR_W = 16;
    localparam int DATA_W = 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] byte_t;

    localparam addr_t RESET_VECTOR = 16'hFFFC;   // Low byte of start address
    localparam byte_t PAGE_ZERO    = 8'h00;      // High byte in zero page modes

endpackage

`default_nettype wire

//--- design/cpu_decode.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_decode import cpu_isa_pkg::*; (
    input  opcode_u  opcode,
    output mstate_e  entry_state,
    output logic     hop,
    output alu_op_e  alu_op,
    output logic     wr_en,
    output reg_sel_e wr_sel,
    output logic     flag_wr,
    output reg_sel_e a_sel,
    output reg_sel_e b_sel,
    output logic     b_acc,
    output logic     is_store,
    output reg_sel_e store_sel
);

    logic     x_group;              // LDX/STX class, indexes with Y
    reg_sel_e idx_reg;              // Register of the X/Y class
    mstate_e  mode;
    logic     mode_ok;

    assign x_group = opcode.f.cc == 2'b10;
    assign idx_reg = x_group ? SEL_X : SEL_Y;

    // Addressing mode from bbb ------------------------------------
    always_comb begin
        mode    = MS_EXEC;
        mode_ok = 1'b1;
        if (opcode.f.cc[0]) begin
            case (opcode.f.bbb)
                3'b001:  mode = MS_ZP;
                3'b010:  mode = MS_EXEC;                    // Immediate
                3'b011:  mode = MS_ABS;
                3'b101:  mode = MS_ZPX;
                3'b110:  mode = MS_ABY;
                3'b111:  mode = MS_ABX;
                default: mode_ok = 1'b0;                    // Indirect modes
            endcase
        end else begin
            case (opcode.f.bbb)
                3'b000:  mode = MS_EXEC;                    // Immediate
                3'b001:  mode = MS_ZP;
                3'b011:  mode = MS_ABS;
                3'b101:  mode = x_group ? MS_ZPY : MS_ZPX;
                3'b111:  mode = x_group ? MS_ABY : MS_ABX;
                default: mode_ok = 1'b0;
            endcase
        end
    end

    // Execute controls --------------------------------------------
    always_comb begin
        entry_state = MS_EXEC;      // Unknown opcodes run as 2-cycle NOP
        hop         = 1'b0;
        alu_op      = ALU_PASS;
        wr_en       = 1'b0;
        wr_sel      = SEL_A;
        flag_wr     = 1'b0;
        a_sel       = SEL_A;
        b_sel       = SEL_MEM;
        b_acc       = 1'b0;
        is_store    = 1'b0;
        store_sel   = SEL_A;
        case (opcode.raw)
            OP_JMP_ABS: entry_state = MS_ABS;
            8'hAA, 8'hA8: begin                             // TAX, TAY
                b_acc   = 1'b1;
                wr_sel  = opcode.raw[1] ? SEL_X : SEL_Y;
                {wr_en, flag_wr} = 2'b11;
            end
            8'h8A, 8'h98: begin                             // TXA, TYA
                b_sel   = opcode.raw[4] ? SEL_Y : SEL_X;
                {wr_en, flag_wr} = 2'b11;
            end
            8'hE8, 8'hC8, 8'hCA, 8'h88: begin               // INX, INY, DEX, DEY
                alu_op  = opcode.raw[5] || opcode.raw == 8'hC8 ? ALU_INC : ALU_DEC;
                b_sel   = opcode.raw inside {8'hE8, 8'hCA} ? SEL_X : SEL_Y;
                wr_sel  = b_sel;
                {wr_en, flag_wr} = 2'b11;
            end
            default: begin
                if (opcode.f.cc == 2'b01 && mode_ok) begin  // ALU group
                    entry_state = mode;
                    hop         = 1'b1;
                    case (opcode.f.aaa)
                        3'b100: begin                       // STA, no immediate form
                            is_store = mode != MS_EXEC;
                            b_sel    = SEL_A;
                        end
                        3'b110: begin
                            alu_op  = ALU_CMP;
                            flag_wr = 1'b1;
                        end
                        default: begin
                            alu_op  = alu_op_e'({1'b0, opcode.f.aaa});
                            {wr_en, flag_wr} = 2'b11;
                        end
                    endcase
                end else if (opcode.f.cc == 2'b00 && opcode.f.bbb == 3'b100) begin
                    entry_state = MS_REL;                   // Conditional branch
                    hop         = 1'b1;
                end else if (opcode.f.cc == 2'b00 && opcode.f.bbb == 3'b110) begin
                    alu_op  = ALU_FLAGSET;
                    flag_wr = 1'b1;
                end else if (opcode.f.aaa[2] && mode_ok &&
                             (opcode.f.cc == 2'b00 || opcode.f.aaa[2:1] == 2'b10)) begin
                    entry_state = mode;
                    hop         = 1'b1;
                    case (opcode.f.aaa)
                        3'b100: begin                       // STX, STY
                            is_store  = opcode.f.bbb inside {3'b001, 3'b011, 3'b101};
                            store_sel = idx_reg;
                            b_sel     = idx_reg;
                        end
                        3'b101: begin                       // LDX, LDY
                            wr_sel = idx_reg;
                            {wr_en, flag_wr} = 2'b11;
                        end
                        default: begin                      // CPY, CPX
                            alu_op  = ALU_CPX;
                            a_sel   = opcode.f.aaa[0] ? SEL_X : SEL_Y;
                            flag_wr = 1'b1;
                        end
                    endcase
                end
            end
        endcase
    end

    always_comb begin
        assert (entry_state inside {MS_ZP, MS_ZPX, MS_ZPY, MS_ABS, MS_ABX, MS_ABY,
                                    MS_EXEC, MS_REL})
            else $error("decoder gave illegal entry state %0d", entry_state);
    end

endmodule

`default_nettype wire

//--- design/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

    // One opcode byte, matched whole or split into its group fields
    typedef union packed {
        logic [7:0] raw;            // Exact opcode matches
        struct packed {
            logic [2:0] aaa;        // Operation within the group
            logic [2:0] bbb;        // Addressing mode
            logic [1:0] cc;         // Instruction class
        } f;
    } opcode_u;

    // ALU group codes line up with aaa so that {0, aaa} selects them
    typedef enum logic [3:0] {
        ALU_ORA     = 4'd0,
        ALU_AND     = 4'd1,
        ALU_EOR     = 4'd2,
        ALU_ADC     = 4'd3,
        ALU_PASS    = 4'd5,         // LDA and all transfers
        ALU_CMP     = 4'd6,
        ALU_SBC     = 4'd7,
        ALU_DEC     = 4'd8,
        ALU_INC     = 4'd9,
        ALU_FLAGSET = 4'd10,        // CLC, SEC, CLI, SEI, CLV, CLD, SED
        ALU_CPX     = 4'd11         // Index register compares
    } alu_op_e;

    typedef enum logic [4:0] {
        MS_FETCH = 5'h00,
        MS_ZP    = 5'h01,
        MS_ZPX   = 5'h02,
        MS_ZPY   = 5'h03,
        MS_ABS   = 5'h04,
        MS_ABS2  = 5'h05,
        MS_ABX   = 5'h06,
        MS_ABY   = 5'h07,
        MS_ABXY2 = 5'h08,           // High byte of indexed absolute
        MS_LAT1  = 5'h09,           // Extra cycle for page cross or store
        MS_EXEC  = 5'h0A,
        MS_REL   = 5'h0B,
        MS_REL1  = 5'h0C,
        MS_REL2  = 5'h0D,
        MS_RST   = 5'h1D,
        MS_RST2  = 5'h1E,
        MS_RST3  = 5'h1F
    } mstate_e;

    typedef enum logic [1:0] {
        SEL_A   = 2'd0,
        SEL_X   = 2'd1,
        SEL_Y   = 2'd2,
        SEL_MEM = 2'd3              // Data input
    } reg_sel_e;

    localparam int FLAG_N = 7;
    localparam int FLAG_V = 6;
    localparam int FLAG_D = 3;      // Stored only, no decimal mode
    localparam int FLAG_I = 2;
    localparam int FLAG_Z = 1;
    localparam int FLAG_C = 0;

    localparam logic [7:0] OP_JMP_ABS = 8'h4C;

endpackage

`default_nettype wire

//--- design/cpu_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_regfile import cpu_bus_pkg::*, cpu_isa_pkg::*; (
    input  logic     CLK,
    input  logic     RESET,
    input  byte_t    din,
    input  logic     wr_en,
    input  logic     flag_wr,
    input  logic     b_acc,
    input  reg_sel_e wr_sel,
    input  reg_sel_e a_sel,
    input  reg_sel_e b_sel,
    input  byte_t    alu_result,
    input  byte_t    alu_flags,
    output byte_t    a_operand,
    output byte_t    b_operand,
    output byte_t    x_reg,
    output byte_t    y_reg,
    output byte_t    status,
    output byte_t    store_data
);

    byte_t a_q;
    byte_t x_q;
    byte_t y_q;
    byte_t p_q;

    function automatic byte_t pick(reg_sel_e sel);
        case (sel)
            SEL_A:   return a_q;
            SEL_X:   return x_q;
            SEL_Y:   return y_q;
            default: return din;
        endcase
    endfunction

    assign a_operand  = pick(a_sel);
    assign b_operand  = b_acc ? a_q : pick(b_sel);              // TAX, TAY read A
    assign store_data = (a_sel == SEL_X) ? x_q : (a_sel == SEL_Y) ? y_q : a_q;
    assign x_reg      = x_q;
    assign y_reg      = y_q;
    assign status     = p_q;

    always_ff @(posedge CLK) begin
        if (wr_en) begin
            case (wr_sel)
                SEL_X:   x_q <= alu_result;
                SEL_Y:   y_q <= alu_result;
                default: a_q <= alu_result;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            p_q <= 8'h24;                                        // Bit 5 high, I set
        end else if (flag_wr) begin
            p_q <= alu_flags;
        end
    end

    a_no_mem_wr: assert property (@(posedge CLK) disable iff (RESET)
        wr_en |-> wr_sel != SEL_MEM);

endmodule

`default_nettype wire

//--- design/cpu_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_sequencer import cpu_bus_pkg::*, cpu_isa_pkg::*; (
    input  logic     CLK,
    input  logic     RESET,
    input  byte_t    din,
    output addr_t    addr,
    output addr_t    wr_addr,
    output logic     wr_req,
    output byte_t    dout,
    input  byte_t    x_reg,
    input  byte_t    y_reg,
    input  byte_t    status,
    input  byte_t    alu_result,
    input  byte_t    store_data,
    output opcode_u  opcode,
    output alu_op_e  alu_op,
    output logic     wr_en,
    output logic     flag_wr,
    output logic     b_acc,
    output reg_sel_e wr_sel,
    output reg_sel_e a_sel,
    output reg_sel_e b_sel
);

    mstate_e    ms;                 // Current micro-state
    addr_t      pc;
    addr_t      ea;                 // Effective address
    byte_t      lo;                 // Low address byte latch
    logic       cout;               // Index add carried into high byte
    logic       am;                 // Bus address from ea, else pc
    opcode_u    dec_in;
    mstate_e    entry_state;
    logic       hop;
    logic       dec_wr_en;
    logic       dec_flag_wr;
    logic       is_store;
    reg_sel_e   dec_a_sel;
    reg_sel_e   store_sel;
    logic       in_exec;
    logic       flag_bit;
    logic       taken;
    addr_t      pc_inc;
    addr_t      pc_rel;
    byte_t      hi_adj;
    logic [8:0] idx_sum;

    assign pc_inc  = pc + 16'd1;
    assign pc_rel  = pc_inc + {{8{din[7]}}, din};                 // Signed offset
    assign idx_sum = {1'b0, din} + {1'b0, (ms == MS_ZPY || ms == MS_ABY) ? y_reg : x_reg};
    assign hi_adj  = din + {7'd0, cout};
    assign dec_in  = (ms == MS_FETCH) ? opcode_u'(din) : opcode;  // New opcode on fetch

    cpu_decode i_decode (
        .opcode      (dec_in),
        .entry_state (entry_state),
        .hop         (hop),
        .alu_op      (alu_op),
        .wr_en       (dec_wr_en),
        .wr_sel      (wr_sel),
        .flag_wr     (dec_flag_wr),
        .a_sel       (dec_a_sel),
        .b_sel       (b_sel),
        .b_acc       (b_acc),
        .is_store    (is_store),
        .store_sel   (store_sel)
    );

    assign in_exec = ms == MS_EXEC;
    assign wr_en   = in_exec & dec_wr_en;
    assign flag_wr = in_exec & dec_flag_wr;
    assign a_sel   = is_store ? store_sel : dec_a_sel;
    assign addr    = am ? ea : pc;
    assign wr_addr = ea;

    // Branch condition, opcode bits 7:6 pick N V C Z, bit 5 the value
    always_comb begin
        case (opcode.raw[7:6])
            2'b00:   flag_bit = status[FLAG_N];
            2'b01:   flag_bit = status[FLAG_V];
            2'b10:   flag_bit = status[FLAG_C];
            default: flag_bit = status[FLAG_Z];
        endcase
    end
    assign taken = flag_bit == opcode.raw[5];

    // ------------------------------------------------------------
    always_ff @(posedge CLK) begin
        if (RESET) begin
            ms     <= MS_RST;
            am     <= 1'b0;
            wr_req <= 1'b0;
        end else begin
            case (ms)
                MS_FETCH: begin
                    opcode <= dec_in;
                    pc     <= pc_inc;
                    ms     <= entry_state;
                    wr_req <= 1'b0;                          // Store ends here
                end
                MS_ZP: begin
                    ea <= {PAGE_ZERO, din};
                    am <= 1'b1;
                    ms <= MS_EXEC;
                end
                MS_ZPX, MS_ZPY: begin
                    ea <= {PAGE_ZERO, idx_sum[7:0]};         // Wraps in page zero
                    am <= 1'b1;
                    ms <= MS_LAT1;
                end
                MS_ABS: begin
                    lo <= din;
                    pc <= pc_inc;
                    ms <= MS_ABS2;
                end
                MS_ABS2: begin
                    if (opcode.raw == OP_JMP_ABS) begin
                        pc <= {din, lo};
                        ms <= MS_FETCH;
                    end else begin
                        ea <= {din, lo};
                        am <= 1'b1;
                        ms <= MS_EXEC;
                    end
                end
                MS_ABX, MS_ABY: begin
                    lo   <= idx_sum[7:0];
                    cout <= idx_sum[8];
                    pc   <= pc_inc;
                    ms   <= MS_ABXY2;
                end
                MS_ABXY2: begin
                    ea <= {hi_adj, lo};
                    am <= 1'b1;
                    ms <= (cout | is_store) ? MS_LAT1 : MS_EXEC;  // Page cross or store
                end
                MS_LAT1: ms <= MS_EXEC;
                MS_EXEC: begin
                    if (hop) pc <= pc_inc;                   // Skip last operand byte
                    if (is_store) begin
                        wr_req <= 1'b1;
                        dout   <= store_data;
                    end
                    am <= 1'b0;
                    ms <= MS_FETCH;
                end
                MS_REL: begin
                    if (taken) begin
                        pc <= pc_rel;
                        ms <= (pc_rel[15:8] == pc_inc[15:8]) ? MS_REL2 : MS_REL1;
                    end else begin
                        pc <= pc_inc;
                        ms <= MS_FETCH;
                    end
                end
                MS_REL1: ms <= MS_REL2;                      // Page cross penalty
                MS_REL2: ms <= MS_FETCH;
                MS_RST: begin
                    pc <= RESET_VECTOR;
                    ms <= MS_RST2;
                end
                MS_RST2: begin
                    lo <= din;
                    pc <= pc_inc;
                    ms <= MS_RST3;
                end
                MS_RST3: begin
                    pc <= {din, lo};
                    ms <= MS_FETCH;
                end
                default: ms <= MS_RST;
            endcase
        end
    end

    a_wr_single: assert property (@(posedge CLK) disable iff (RESET) wr_req |=> !wr_req);

endmodule

`default_nettype wire

//--- design/cpu_top.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_top import cpu_bus_pkg::*, cpu_isa_pkg::*; (
    input  logic  CLK,
    input  logic  RESET,
    input  byte_t din,
    output addr_t addr,
    output addr_t wr_addr,
    output logic  wr_req,
    output byte_t dout
);

    opcode_u  opcode;
    alu_op_e  alu_op;
    logic     wr_en;
    logic     flag_wr;
    logic     b_acc;
    reg_sel_e wr_sel;
    reg_sel_e a_sel;
    reg_sel_e b_sel;
    byte_t    a_operand;
    byte_t    b_operand;
    byte_t    x_reg;
    byte_t    y_reg;
    byte_t    status;
    byte_t    store_data;
    byte_t    alu_result;
    byte_t    alu_flags;

    cpu_sequencer i_sequencer (
        .CLK        (CLK),
        .RESET      (RESET),
        .din        (din),
        .addr       (addr),
        .wr_addr    (wr_addr),
        .wr_req     (wr_req),
        .dout       (dout),
        .x_reg      (x_reg),
        .y_reg      (y_reg),
        .status     (status),
        .alu_result (alu_result),
        .store_data (store_data),
        .opcode     (opcode),
        .alu_op     (alu_op),
        .wr_en      (wr_en),
        .flag_wr    (flag_wr),
        .b_acc      (b_acc),
        .wr_sel     (wr_sel),
        .a_sel      (a_sel),
        .b_sel      (b_sel)
    );

    cpu_regfile i_regfile (
        .CLK        (CLK),
        .RESET      (RESET),
        .din        (din),
        .wr_en      (wr_en),
        .flag_wr    (flag_wr),
        .b_acc      (b_acc),
        .wr_sel     (wr_sel),
        .a_sel      (a_sel),
        .b_sel      (b_sel),
        .alu_result (alu_result),
        .alu_flags  (alu_flags),
        .a_operand  (a_operand),
        .b_operand  (b_operand),
        .x_reg      (x_reg),
        .y_reg      (y_reg),
        .status     (status),
        .store_data (store_data)
    );

    cpu_alu i_alu (
        .alu_op     (alu_op),
        .a_operand  (a_operand),
        .b_operand  (b_operand),
        .status     (status),
        .opcode     (opcode),
        .alu_result (alu_result),
        .alu_flags  (alu_flags)
    );

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -f verilog.f --top-module cpu_tb -o cpu_tb \
    && ./obj_dir/cpu_tb \
    || exit 1

//--- testbench/cpu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_tb import cpu_bus_pkg::*, cpu_isa_pkg::*; ();

    localparam int NUM_KINDS    = 11;
    localparam int NUM_ROWS     = 55;           // Five rounds of every kind
    localparam int TIMEOUT      = 200;          // Cycles allowed per store
    localparam int RESET_CYCLES = 16;

    localparam logic [3:0] K_ALU  = 4'd0;       // LDA, SEC/CLC, ALU op, STA
    localparam logic [3:0] K_ZP   = 4'd1;
    localparam logic [3:0] K_ZPX  = 4'd2;
    localparam logic [3:0] K_ABS  = 4'd3;
    localparam logic [3:0] K_ABX  = 4'd4;
    localparam logic [3:0] K_ABY  = 4'd5;
    localparam logic [3:0] K_INX  = 4'd6;       // LDX, INX, STX
    localparam logic [3:0] K_DEY  = 4'd7;       // LDY, DEY, STY
    localparam logic [3:0] K_XFER = 4'd8;       // Transfers through A, X, Y
    localparam logic [3:0] K_BR   = 4'd9;       // CMP then conditional branch
    localparam logic [3:0] K_JMP  = 4'd10;

    typedef struct packed {
        logic [3:0] kind;
        logic [2:0] sel;                        // ALU op or branch select
        logic       flag;                       // Carry in, or force equal compare
        byte_t      a;
        byte_t      b;
        byte_t      dst;                        // Zero page store target
        addr_t      base;                       // Load address before indexing
        addr_t      start;
        addr_t      exp_addr;
        byte_t      exp_data;
    } row_t;

    logic  CLK = 1'b0;
    logic  RESET;
    byte_t din;
    addr_t addr;
    addr_t wr_addr;
    logic  wr_req;
    byte_t dout;

    byte_t mem [0:65535];
    row_t  rows [NUM_ROWS];
    addr_t mem_wa;
    byte_t mem_wd;

    cpu_top i_dut (
        .CLK     (CLK),
        .RESET   (RESET),
        .din     (din),
        .addr    (addr),
        .wr_addr (wr_addr),
        .wr_req  (wr_req),
        .dout    (dout)
    );

    always #2 CLK = ~CLK;                       // 4 ns period

    assign din = mem[addr];                     // Combinational read

    // Store captured at the edge, applied just after it
    always @(posedge CLK) begin
        if (wr_req === 1'b1) begin
            mem_wa = wr_addr;
            mem_wd = dout;
            #1 mem[mem_wa] = mem_wd;
        end
    end

    // Opcode tables ----------------------------------------------
    function automatic byte_t alu_opcode(input logic [2:0] sel);
        case (sel)
            3'd0:    return 8'h09;              // ORA #
            3'd1:    return 8'h29;              // AND #
            3'd2:    return 8'h49;              // EOR #
            3'd3:    return 8'h69;              // ADC #
            default: return 8'hE9;              // SBC #
        endcase
    endfunction

    function automatic byte_t branch_opcode(input logic [2:0] sel);
        case (sel[1:0])
            2'd0:    return 8'hF0;              // BEQ
            2'd1:    return 8'hD0;              // BNE
            2'd2:    return 8'hB0;              // BCS
            default: return 8'h90;              // BCC
        endcase
    endfunction

    // Z is equality, C is no borrow on A - B
    function automatic logic branch_taken(input logic [2:0] sel, input byte_t a,
                                          input byte_t b);
        case (sel[1:0])
            2'd0:    return a == b;
            2'd1:    return a != b;
            2'd2:    return a >= b;
            default: return a < b;
        endcase
    endfunction

    // Checks -----------------------------------------------------
    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
            $display("tests failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic check_data(input byte_t got, input byte_t exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
            $display("tests failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // Table of programs and expected stores ----------------------
    task automatic build_table();
        logic [31:0] r;
        logic [31:0] s;
        logic [8:0]  t;
        row_t        w;
        for (int i = 0; i < NUM_ROWS; i++) begin
            r          = $urandom;
            s          = $urandom;
            w          = '0;
            w.kind     = 4'(i % NUM_KINDS);
            w.sel      = 3'((i / NUM_KINDS) % 5);
            w.flag     = r[16];
            w.a        = r[7:0];
            w.b        = r[15:8];
            w.dst      = 8'h10 + 8'(i);
            w.start    = {8'h02 + {1'b0, s[6:0]}, s[15:8]};
            w.base     = 16'hF000 + {5'd0, s[26:16]};
            w.exp_addr = {PAGE_ZERO, w.dst};
            w.exp_data = w.a;                   // Loads store the loaded byte
            case (w.kind)
                K_ALU: begin
                    case (w.sel)
                        3'd0: w.exp_data = w.a | w.b;
                        3'd1: w.exp_data = w.a & w.b;
                        3'd2: w.exp_data = w.a ^ w.b;
                        3'd3: begin
                            t          = {1'b0, w.a} + {1'b0, w.b} + {8'd0, w.flag};
                            w.exp_data = t[7:0];
                        end
                        default: begin      // Borrow is the inverted carry
                            t          = {1'b0, w.a} - {1'b0, w.b} - {8'd0, ~w.flag};
                            w.exp_data = t[7:0];
                        end
                    endcase
                end
                K_ZP:   w.base = {PAGE_ZERO, 1'b1, s[22:16]};
                K_ZPX:  w.base = {PAGE_ZERO, s[23:16]};
                K_INX:  w.exp_data = w.a + 8'd1;
                K_DEY:  w.exp_data = w.a - 8'd1;
                K_XFER: w.exp_data = w.a + 8'd2;
                K_BR: begin
                    if (w.flag) w.b = w.a;
                    if (((i / NUM_KINDS) % 2) == 1) w.start[7:0] = 8'hF8;  // Target on next page
                    if (!branch_taken(w.sel, w.a, w.b)) w.exp_addr = {PAGE_ZERO, w.dst + 8'h40};
                end
                default: ;
            endcase
            rows[i] = w;
        end
    endtask

    // Program placement ------------------------------------------
    task automatic emit(inout addr_t p, input byte_t v);
        mem[p] = v;
        p      = p + 16'd1;
    endtask

    task automatic self_loop(inout addr_t p);
        addr_t here;
        here = p;
        emit(p, OP_JMP_ABS);
        emit(p, here[7:0]);
        emit(p, here[15:8]);
    endtask

    task automatic place_program(input row_t w);
        addr_t p;
        addr_t tgt;
        p   = w.start;
        tgt = w.start + 16'h0030;
        mem[RESET_VECTOR]         = w.start[7:0];
        mem[RESET_VECTOR + 16'd1] = w.start[15:8];
        case (w.kind)
            K_ALU: begin
                emit(p, 8'hA9);
                emit(p, w.a);
                emit(p, w.flag ? 8'h38 : 8'h18);                // SEC or CLC
                emit(p, alu_opcode(w.sel));
                emit(p, w.b);
            end
            K_ZP: begin
                mem[w.base] = w.a;
                emit(p, 8'hA5);
                emit(p, w.base[7:0]);
            end
            K_ZPX: begin
                mem[{PAGE_ZERO, w.base[7:0] + w.b}] = w.a;      // Wraps in page zero
                emit(p, 8'hA2);
                emit(p, w.b);
                emit(p, 8'hB5);
                emit(p, w.base[7:0]);
            end
            K_ABS, K_ABX, K_ABY: begin
                mem[w.base + ((w.kind == K_ABS) ? 16'd0 : {8'h00, w.b})] = w.a;
                if (w.kind != K_ABS) begin
                    emit(p, (w.kind == K_ABX) ? 8'hA2 : 8'hA0);
                    emit(p, w.b);
                end
                emit(p, (w.kind == K_ABS) ? 8'hAD : (w.kind == K_ABX) ? 8'hBD : 8'hB9);
                emit(p, w.base[7:0]);
                emit(p, w.base[15:8]);
            end
            K_INX: begin
                emit(p, 8'hA2);
                emit(p, w.a);
                emit(p, 8'hE8);
            end
            K_DEY: begin
                emit(p, 8'hA0);
                emit(p, w.a);
                emit(p, 8'h88);
            end
            K_XFER: begin
                emit(p, 8'hA2);
                emit(p, w.a);
                emit(p, 8'hE8);                                 // INX
                emit(p, 8'h8A);                                 // TXA
                emit(p, 8'hA8);                                 // TAY
                emit(p, 8'hC8);                                 // INY
                emit(p, 8'h98);                                 // TYA
            end
            K_BR: begin
                emit(p, 8'hA9);
                emit(p, w.a);
                emit(p, 8'hC9);
                emit(p, w.b);
                emit(p, branch_opcode(w.sel));
                emit(p, 8'h05);                                 // Skips store and loop
                emit(p, 8'h85);
                emit(p, w.dst + 8'h40);                         // Not taken path
                self_loop(p);
            end
            K_JMP: begin
                emit(p, 8'hA9);
                emit(p, w.a);
                emit(p, OP_JMP_ABS);
                emit(p, tgt[7:0]);
                emit(p, tgt[15:8]);
                emit(p, 8'h85);
                emit(p, w.dst + 8'h40);                         // Skipped by the jump
                p = tgt;
            end
            default: ;
        endcase
        emit(p, (w.kind == K_INX) ? 8'h86 : (w.kind == K_DEY) ? 8'h84 : 8'h85);
        emit(p, w.dst);
        self_loop(p);                                           // Park after the store
    endtask

    // One row: reset into the program, wait for its store --------
    task automatic run_row(input int idx);
        row_t  w;
        int    cyc;
        logic  found;
        addr_t got_addr;
        byte_t got_data;
        w = rows[idx];
        @(posedge CLK);
        #1 RESET = 1'b1;
        place_program(w);
        for (cyc = 0; cyc < RESET_CYCLES; cyc++) begin
            @(posedge CLK);
            if (cyc > 0 && wr_req !== 1'b0) begin
                $display("write request seen during reset in row %0d", idx);
                $display("tests failed");
                $fatal(1, "write during reset");
            end
        end
        #1 RESET = 1'b0;
        // RST, RST2 and RST3 read the vector, then the first fetch
        repeat (3) @(posedge CLK);
        #1;
        check_addr(addr, w.start, $sformatf("row %0d first fetch address", idx));
        found = 1'b0;
        cyc   = 0;
        while (!found && cyc < TIMEOUT) begin
            @(posedge CLK);
            cyc++;
            if (wr_req === 1'b1) begin
                found    = 1'b1;
                got_addr = wr_addr;
                got_data = dout;
            end
        end
        if (!found) begin
            $display("no store seen within %0d cycles in row %0d", TIMEOUT, idx);
            $display("tests failed");
            $fatal(1, "timeout");
        end
        check_addr(got_addr, w.exp_addr, $sformatf("row %0d kind %0d address", idx, w.kind));
        check_data(got_data, w.exp_data, $sformatf("row %0d kind %0d data", idx, w.kind));
    endtask

    initial begin
        int unsigned seed_r;
        addr_t       fill_a;
        RESET  = 1'b1;
        seed_r = $urandom(32'hb5766218);
        for (int i = 0; i < 65536; i++) begin
            fill_a      = 16'(i);
            mem[fill_a] = fill_a[15:8] ^ fill_a[7:0] ^ 8'hA5;
        end
        build_table();
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
design/cpu_bus_pkg.sv
design/cpu_isa_pkg.sv
design/cpu_decode.sv
design/cpu_alu.sv
design/cpu_regfile.sv
design/cpu_sequencer.sv
design/cpu_top.sv
testbench/cpu_tb.sv
